//--- all.f
hw/tlb_pkg.sv
hw/tlb_way_bank.sv
hw/tlb_lookup_stage.sv
hw/tlb_attr_merge.sv
hw/tlb_region_table.sv
hw/tlb_miss_queue.sv
hw/tlb_top.sv
dv/tlb_tb.sv

//--- dv/tlb_tb.sv
// Random two-channel traffic over a small page pool against a model, with 16 queue slots and 4 credits
`timescale 1ns/1ps

module tlb_tb;

  localparam int MISSQ_DEPTH    = 16;
  localparam int WALKER_CREDITS = 4;
  localparam int SETS           = 2 ** tlb_pkg::TLB_INDEX_W;
  localparam int NUM_CYCLES     = 3000;
  localparam int DRAIN_LIMIT    = 500;  // Cycles allowed for the queue and walker to empty

  logic                   clk;
  logic                   rst;
  tlb_pkg::tlb_write_t    tlb_wr;
  tlb_pkg::region_write_t rgn_wr;
  logic                   d_req_valid;
  tlb_pkg::lookup_req_t   d_req;
  tlb_pkg::data_tag_t     d_tag;
  logic                   d_stall;
  logic                   f_req_valid;
  tlb_pkg::lookup_req_t   f_req;
  logic                   credit;
  tlb_pkg::tlb_result_t   d_result;
  tlb_pkg::data_tag_t     d_tag_out;
  tlb_pkg::tlb_result_t   f_result;
  logic                   miss_valid;
  tlb_pkg::miss_t         miss;

  integer seed;
  int     errors;
  int     timeouts;
  int     checks;
  int     hits;
  int     issued;
  int     drops;
  int     holds;
  int     cyc;
  int     in_flight;     // Walks the walker still owes a credit for
  int     waited;
  bit     hold_returns;  // Walker withholds credits to build back-pressure

  // ============================================================
  // Reference model state
  // ============================================================
  tlb_pkg::tlb_entry_t   mdl_mem [2][SETS];
  tlb_pkg::region_attr_t mdl_rgn [8];
  tlb_pkg::miss_t        mdl_q [$];
  int                    mdl_credits;
  int                    ret_due [$];  // Cycle at which each outstanding walk returns
  tlb_pkg::tlb_result_t  exp_d_raw;    // Registered entry before the region merge
  tlb_pkg::omd_t         exp_d_omd;
  tlb_pkg::data_tag_t    exp_d_tag;
  tlb_pkg::tlb_result_t  exp_f_raw;
  tlb_pkg::omd_t         exp_f_omd;

  tlb_top #(
    .MISSQ_DEPTH(MISSQ_DEPTH),
    .WALKER_CREDITS(WALKER_CREDITS)
  ) i_tlb_top (
    .clk, .rst, .tlb_wr_i(tlb_wr), .rgn_wr_i(rgn_wr),
    .d_req_valid_i(d_req_valid), .d_req_i(d_req), .d_tag_i(d_tag), .d_stall_i(d_stall),
    .f_req_valid_i(f_req_valid), .f_req_i(f_req), .credit_i(credit),
    .d_result_o(d_result), .d_tag_o(d_tag_out), .f_result_o(f_result),
    .miss_valid_o(miss_valid), .miss_o(miss)
  );

  always #5 clk = ~clk;  // 10 ns period

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  // Way 0 is searched last so that it wins a double hit
  task automatic lookup_model(input tlb_pkg::lookup_req_t req, output logic hit,
                              output tlb_pkg::tlb_entry_t ent);
    logic [6:0] idx;
    logic [8:0] tg;
    idx = req.vaddr[22:16];
    tg  = req.vaddr[31:23];
    hit = 1'b0;
    ent = '0;
    for (int w = 1; w >= 0; w--) begin
      if (mdl_mem[w][idx].valid && mdl_mem[w][idx].tag == tg &&
          mdl_mem[w][idx].asid == req.asid) begin
        hit = 1'b1;
        ent = mdl_mem[w][idx];
      end
    end
  endtask

  function automatic tlb_pkg::tlb_entry_t merge_expected(input tlb_pkg::tlb_entry_t ent,
                                                         input tlb_pkg::omd_t omd);
    tlb_pkg::tlb_entry_t   res;
    tlb_pkg::region_attr_t ra;
    res = ent;
    ra  = mdl_rgn[ent.pte.rgn];
    if (ent.valid) begin
      if (ent.pte.urwx == 3'd0) res.pte.urwx = ra.at[0].rwx;  // Zero field means inherit
      if (ent.pte.srwx == 3'd0) res.pte.srwx = ra.at[1].rwx;
      if (ent.pte.hrwx == 3'd0) res.pte.hrwx = ra.at[2].rwx;
      if (ent.pte.mrwx == 3'd0) res.pte.mrwx = ra.at[3].rwx;
      res.pte.cache = tlb_pkg::merge_cache(ra.at[omd].cache, ent.pte.cache);
    end
    return res;
  endfunction

  function automatic tlb_pkg::tlb_result_t form_result(input logic vld,
                                                       input tlb_pkg::lookup_req_t req,
                                                       input logic hit,
                                                       input tlb_pkg::tlb_entry_t ent);
    tlb_pkg::tlb_result_t res;
    res = '0;  // Idle or missed lookups load all zero
    if (vld && hit) begin
      res.valid = 1'b1;
      res.entry = ent;
      res.paddr = {ent.pte.ppn, req.vaddr[15:0]};
      res.vaddr = req.vaddr;
    end
    return res;
  endfunction

  // True when the page and ASID already sit in the model queue
  function automatic logic page_pending(input tlb_pkg::lookup_req_t req);
    logic found;
    found = 1'b0;
    foreach (mdl_q[i]) begin
      if (mdl_q[i].vpn == req.vaddr[31:16] && mdl_q[i].asid == req.asid) found = 1'b1;
    end
    return found;
  endfunction

  // ============================================================
  // Checks run mid-cycle once outputs have settled after the last edge
  // ============================================================
  task automatic check_outputs();
    tlb_pkg::tlb_result_t exp_d;
    tlb_pkg::tlb_result_t exp_f;
    logic                 exp_issue;
    exp_d       = exp_d_raw;
    exp_d.entry = merge_expected(exp_d_raw.entry, exp_d_omd);
    exp_f       = exp_f_raw;
    exp_f.entry = merge_expected(exp_f_raw.entry, exp_f_omd);
    exp_issue   = (mdl_q.size() != 0) && (mdl_credits != 0);
    checks++;
    if (d_result !== exp_d) report_mismatch($sformatf("data result %h, expected %h",
                                                      d_result, exp_d));
    if (d_tag_out !== exp_d_tag) report_mismatch($sformatf("data tag %h, expected %h",
                                                           d_tag_out, exp_d_tag));
    if (f_result !== exp_f) report_mismatch($sformatf("fetch result %h, expected %h",
                                                      f_result, exp_f));
    if (miss_valid !== exp_issue) report_mismatch($sformatf("miss valid %b, expected %b",
                                                            miss_valid, exp_issue));
    if (exp_issue) begin
      if (miss !== mdl_q[0]) report_mismatch($sformatf("miss %h, expected %h", miss, mdl_q[0]));
    end
    if (miss_valid === 1'b1) begin
      if (mdl_credits == 0) report_mismatch("miss issued with no walker credit left");
      in_flight++;
      issued++;
      if (in_flight > WALKER_CREDITS) report_mismatch($sformatf("%0d walks outstanding",
                                                                in_flight));
      ret_due.push_back(cyc + 1 + ({$random(seed)} % 6));  // Walk takes 1 to 6 cycles
    end
  endtask

  // Applies the coming clock edge to the model, using the inputs now driven
  task automatic update_model();
    logic                f_hit;
    logic                d_hit;
    tlb_pkg::tlb_entry_t f_ent;
    tlb_pkg::tlb_entry_t d_ent;
    logic                f_miss;
    logic                d_miss;
    logic                issue;
    logic                room;
    lookup_model(f_req, f_hit, f_ent);
    lookup_model(d_req, d_hit, d_ent);
    issue     = (mdl_q.size() != 0) && (mdl_credits != 0);
    room      = mdl_q.size() <= MISSQ_DEPTH - 2;  // Both pushers need a slot each
    exp_f_raw = form_result(f_req_valid, f_req, f_hit, f_ent);
    exp_f_omd = f_req.omd;
    if (!d_stall) begin
      exp_d_raw = form_result(d_req_valid, d_req, d_hit, d_ent);
      exp_d_omd = d_req.omd;
      exp_d_tag = d_tag;
    end else if (d_req_valid) begin
      holds++;
    end
    hits   += int'(f_req_valid && f_hit) + int'(d_req_valid && !d_stall && d_hit);
    f_miss  = f_req_valid && !f_hit && !page_pending(f_req);
    d_miss  = d_req_valid && !d_stall && !d_hit && !page_pending(d_req);
    if (issue) begin
      mdl_q.delete(0);
      mdl_credits--;
    end
    if (f_miss || d_miss) begin
      if (room) begin
        if (f_miss) mdl_q.push_back('{vpn: f_req.vaddr[31:16], asid: f_req.asid});
        if (d_miss) mdl_q.push_back('{vpn: d_req.vaddr[31:16], asid: d_req.asid});
      end else begin
        drops++;
      end
    end
    mdl_credits += int'(credit);
    if (tlb_wr.wr) mdl_mem[tlb_wr.way][tlb_wr.index] = tlb_wr.entry;
    if (rgn_wr.wr) mdl_rgn[rgn_wr.rgn] = rgn_wr.attr;
  endtask

  // Small pool of 4 tags, 8 sets and 2 ASIDs so pages repeat often
  function automatic tlb_pkg::lookup_req_t random_req();
    tlb_pkg::lookup_req_t req;
    logic [31:0]          r;
    r               = $random(seed);
    req.vaddr       = $random(seed);
    req.vaddr[31:23] = {7'd0, r[1:0]};
    req.vaddr[22:16] = {4'd0, r[4:2]};
    req.asid        = {15'd0, r[5]} + 16'd1;
    req.omd         = tlb_pkg::omd_t'(r[7:6]);
    return req;
  endfunction

  // ============================================================
  // Stimulus is driven 1 ns after the rising edge
  // ============================================================
  task automatic drive_inputs(input bit active);
    logic [63:0] r;
    logic [31:0] c;
    logic [31:0] t;
    int          slot;
    cyc++;
    hold_returns = active && ((cyc / 200) % 3 == 2);
    credit       = 1'b0;
    slot         = -1;
    if (!hold_returns) begin
      foreach (ret_due[i]) begin
        if (slot < 0 && ret_due[i] <= cyc) slot = i;
      end
    end
    if (slot >= 0) begin
      credit = 1'b1;  // At most one finished walk per cycle
      ret_due.delete(slot);
      in_flight--;
    end
    r                 = {$random(seed), $random(seed)};
    c                 = $random(seed);
    d_req_valid       = active && ({$random(seed)} % 4 != 0);
    f_req_valid       = active && ({$random(seed)} % 4 != 0);
    d_req             = random_req();
    f_req             = random_req();
    t                 = $random(seed);
    d_tag             = t[$bits(tlb_pkg::data_tag_t)-1:0];
    d_stall           = active && (c[31:30] == 2'd0);
    tlb_wr            = '0;
    tlb_wr.wr         = active && (c[29:27] == 3'd0);
    tlb_wr.way        = c[0];
    tlb_wr.index      = {4'd0, c[3:1]};
    tlb_wr.entry.valid = c[6:4] != 3'd0;  // Some writes invalidate
    tlb_wr.entry.tag  = {7'd0, c[8:7]};
    tlb_wr.entry.asid = {15'd0, c[9]} + 16'd1;
    tlb_wr.entry.pte  = r[$bits(tlb_pkg::pte_t)-1:0];  // Cache codes include 4 to 7
    if (c[11:10] == 2'd0) tlb_wr.entry.pte.urwx = 3'd0;
    if (c[13:12] == 2'd0) tlb_wr.entry.pte.srwx = 3'd0;
    if (c[15:14] == 2'd0) tlb_wr.entry.pte.hrwx = 3'd0;
    if (c[17:16] == 2'd0) tlb_wr.entry.pte.mrwx = 3'd0;
    rgn_wr            = '0;
    rgn_wr.wr         = active && (c[21:18] == 4'd0);
    rgn_wr.rgn        = c[24:22];
    rgn_wr.attr       = r[63:64-$bits(tlb_pkg::region_attr_t)];
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    tlb_wr       = '0;
    rgn_wr       = '0;
    d_req_valid  = 1'b0;
    d_req        = '0;
    d_tag        = '0;
    d_stall      = 1'b0;
    f_req_valid  = 1'b0;
    f_req        = '0;
    credit       = 1'b0;
    seed         = 32'heb9d9f44;
    errors       = 0;
    timeouts     = 0;
    checks       = 0;
    hits         = 0;
    issued       = 0;
    drops        = 0;
    holds        = 0;
    cyc          = 0;
    in_flight    = 0;
    hold_returns = 1'b0;
    mdl_credits  = WALKER_CREDITS;
    exp_d_raw    = '0;
    exp_d_omd    = tlb_pkg::OMD_USER;
    exp_d_tag    = '0;
    exp_f_raw    = '0;
    exp_f_omd    = tlb_pkg::OMD_USER;
    foreach (mdl_mem[w, s]) mdl_mem[w][s] = '0;
    foreach (mdl_rgn[g]) mdl_rgn[g] = '0;

    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    if (d_result.valid !== 1'b0 || f_result.valid !== 1'b0 || miss_valid !== 1'b0) begin
      report_mismatch("result valids or miss valid not low after reset");
    end

    for (int n = 0; n < NUM_CYCLES; n++) begin
      check_outputs();
      update_model();
      @(posedge clk);
      #1 drive_inputs(1'b1);
      @(negedge clk);
    end

    // Let the walker finish everything that is queued or in flight
    waited = 0;
    while ((mdl_q.size() != 0 || in_flight != 0 || miss_valid !== 1'b0) &&
           waited < DRAIN_LIMIT) begin
      check_outputs();
      update_model();
      @(posedge clk);
      #1 drive_inputs(1'b0);
      @(negedge clk);
      waited++;
    end
    if (waited >= DRAIN_LIMIT) begin
      timeouts++;
      $display("Timeout: miss queue or walker did not drain within %0d cycles", DRAIN_LIMIT);
    end

    $display("Errors %0d, timeouts %0d over %0d checks (hits %0d, issued %0d, drops %0d, %s",
             errors, timeouts, checks, hits, issued, drops,
             $sformatf("stall holds %0d)", holds));
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- hw/tlb_attr_merge.sv
// Purely combinational, and an invalid entry passes through unchanged as all zero
`timescale 1ns/1ps

module tlb_attr_merge (
  input  tlb_pkg::tlb_entry_t   entry_i,
  input  tlb_pkg::omd_t         omd_i,    // Mode of the registered lookup
  input  tlb_pkg::region_attr_t attr_i,   // Attributes of the entry's region
  output tlb_pkg::tlb_entry_t   entry_o
);

  always_comb begin
    entry_o = entry_i;
    if (entry_i.valid) begin
      // Zero permissions in the PTE defer to the region for that mode
      if (entry_i.pte.urwx == '0) begin
        entry_o.pte.urwx = attr_i.at[tlb_pkg::OMD_USER].rwx;
      end
      if (entry_i.pte.srwx == '0) begin
        entry_o.pte.srwx = attr_i.at[tlb_pkg::OMD_SUPER].rwx;
      end
      if (entry_i.pte.hrwx == '0) begin
        entry_o.pte.hrwx = attr_i.at[tlb_pkg::OMD_HYPER].rwx;
      end
      if (entry_i.pte.mrwx == '0) begin
        entry_o.pte.mrwx = attr_i.at[tlb_pkg::OMD_MACHINE].rwx;
      end
      entry_o.pte.cache = tlb_pkg::merge_cache(attr_i.at[omd_i].cache,  // Only the
                                               entry_i.pte.cache);      // current mode counts
    end
  end

endmodule

//--- hw/tlb_lookup_stage.sv
// One-cycle lookup result with stall hold, and a stalled request is neither looked up nor a miss
`timescale 1ns/1ps

module tlb_lookup_stage #(
  parameter bit HAS_TAG = 1'b1  // Data channel carries its load, store and ROB tag along
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid_i,
  input  logic                 stall_i,       // Tied low on the fetch channel
  input  tlb_pkg::lookup_req_t req_i,
  input  tlb_pkg::data_tag_t   tag_i,
  input  logic                 hit_i,
  input  tlb_pkg::tlb_entry_t  hit_entry_i,
  input  logic                 pending_i,     // Page already waits in the miss queue
  output tlb_pkg::tlb_result_t result_o,
  output tlb_pkg::omd_t        omd_o,         // Mode registered with the result
  output tlb_pkg::data_tag_t   tag_o,
  output logic                 miss_o,
  output tlb_pkg::miss_t       miss_o_entry
);

  tlb_pkg::tlb_result_t result_d;
  tlb_pkg::tlb_result_t result_q;
  tlb_pkg::omd_t        omd_q;

  // A miss or an idle cycle loads an all-zero result
  always_comb begin
    result_d = '0;
    if (req_valid_i && hit_i) begin
      result_d.valid = 1'b1;
      result_d.entry = hit_entry_i;
      result_d.paddr = {hit_entry_i.pte.ppn, req_i.vaddr[tlb_pkg::PAGE_SHIFT-1:0]};
      result_d.vaddr = req_i.vaddr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_q <= '0;
      omd_q    <= tlb_pkg::OMD_USER;
    end else if (!stall_i) begin  // Stall keeps the old result for the consumer
      result_q <= result_d;
      omd_q    <= req_i.omd;
    end
  end

  assign result_o = result_q;
  assign omd_o    = omd_q;

  generate
    if (HAS_TAG) begin : g_tag
      tlb_pkg::data_tag_t tag_q;
      always_ff @(posedge clk) begin
        if (rst) begin
          tag_q <= '0;
        end else if (!stall_i) begin
          tag_q <= tag_i;
        end
      end
      assign tag_o = tag_q;
    end else begin : g_no_tag
      assign tag_o = '0;  // Fetch has nothing to carry
    end
  endgenerate

  // Miss request goes to the queue in the same cycle as the lookup
  assign miss_o = req_valid_i && !stall_i && !hit_i && !pending_i;

  assign miss_o_entry.vpn  = req_i.vaddr[tlb_pkg::VADDR_W-1:tlb_pkg::PAGE_SHIFT];
  assign miss_o_entry.asid = req_i.asid;

endmodule

//--- hw/tlb_miss_queue.sv
// MISSQ_DEPTH must be a power of two of at least 4, and the walker returns exactly one credit per issue
`timescale 1ns/1ps

module tlb_miss_queue #(
  parameter int MISSQ_DEPTH    = 16,
  parameter int WALKER_CREDITS = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           push_a_i,     // Fetch miss, enqueued ahead of data
  input  tlb_pkg::miss_t miss_a_i,
  input  logic           push_b_i,     // Data miss
  input  tlb_pkg::miss_t miss_b_i,
  input  tlb_pkg::miss_t probe_a_i,
  input  tlb_pkg::miss_t probe_b_i,
  output logic           pending_a_o,
  output logic           pending_b_o,
  input  logic           credit_i,     // One pulse per finished walk
  output logic           miss_valid_o,
  output tlb_pkg::miss_t miss_o
);

  localparam int AW = $clog2(MISSQ_DEPTH);
  localparam int NW = $clog2(MISSQ_DEPTH + 1);
  localparam int CW = $clog2(WALKER_CREDITS + 1);

  tlb_pkg::miss_t mem_q [MISSQ_DEPTH];  // Slot payload

  logic [AW-1:0]          head_q;
  logic [AW-1:0]          tail_q;
  logic [AW-1:0]          tail_b;
  logic [NW-1:0]          count_q;
  logic [CW-1:0]          credits_q;
  logic                   room;
  logic                   do_a;
  logic                   do_b;
  logic                   issue;
  logic [MISSQ_DEPTH-1:0] occ;

  // ==========================================================
  // Push side
  // ==========================================================
  // Two free slots cover both pushers, else both misses drop and retry
  assign room   = count_q <= NW'(MISSQ_DEPTH - 2);
  assign do_a   = push_a_i && room;
  assign do_b   = push_b_i && room;
  assign tail_b = tail_q + AW'(do_a);  // Data lands behind fetch in the same cycle

  always_ff @(posedge clk) begin
    if (do_a) begin
      mem_q[tail_q] <= miss_a_i;
    end
    if (do_b) begin
      mem_q[tail_b] <= miss_b_i;
    end
  end

  // Only slots between head and tail take part in the pending search
  always_comb begin
    logic [AW-1:0] rel;
    pending_a_o = 1'b0;
    pending_b_o = 1'b0;
    for (int i = 0; i < MISSQ_DEPTH; i++) begin
      rel    = AW'(i) - head_q;  // Distance from the head, wrapping
      occ[i] = NW'(rel) < count_q;
      if (occ[i] && (mem_q[i] == probe_a_i)) begin
        pending_a_o = 1'b1;
      end
      if (occ[i] && (mem_q[i] == probe_b_i)) begin
        pending_b_o = 1'b1;
      end
    end
  end

  // ==========================================================
  // Issue side
  // ==========================================================
  assign issue        = (count_q != '0) && (credits_q != '0);
  assign miss_valid_o = issue;  // Head pops at the same edge
  assign miss_o       = mem_q[head_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q    <= '0;
      tail_q    <= '0;
      count_q   <= '0;
      credits_q <= CW'(WALKER_CREDITS);  // Walker starts idle
    end else begin
      head_q    <= head_q + AW'(issue);
      tail_q    <= tail_b + AW'(do_b);
      count_q   <= count_q + NW'(do_a) + NW'(do_b) - NW'(issue);
      credits_q <= credits_q - CW'(issue) + CW'(credit_i);
    end
  end

  // Occupancy accumulates over many cycles of pushes and pops
  a_occupancy_bound: assert property (@(posedge clk) disable iff (rst)
    count_q <= NW'(MISSQ_DEPTH));

  // A walker that returns more credits than it took would break the limit
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits_q <= CW'(WALKER_CREDITS));

endmodule

//--- hw/tlb_pkg.sv
// Sized for 32-bit virtual addresses, 64 KiB pages and 128 sets per way, with cache codes 4 to 7 invalid
package tlb_pkg;

  // ==========================================================
  // Widths
  // ==========================================================
  parameter int VADDR_W     = 32;
  parameter int PAGE_SHIFT  = 16;  // Page offset bits
  parameter int TLB_INDEX_W = 7;   // Set index is vaddr[22:16]
  parameter int TAG_W       = 9;   // Tag is vaddr[31:23]
  parameter int ASID_W      = 16;
  parameter int PPN_W       = 16;  // PPN plus page offset gives a 32-bit physical address
  parameter int ROB_W       = 6;
  parameter int RGN_W       = 3;   // Eight regions
  parameter int CACHE_W     = 4;

  // Codes 8 to 15 are the write-through and write-back kinds
  parameter logic [CACHE_W-1:0] NC_NB         = 4'd0;
  parameter logic [CACHE_W-1:0] NON_CACHEABLE = 4'd1;
  parameter logic [CACHE_W-1:0] CACHEABLE_NB  = 4'd2;
  parameter logic [CACHE_W-1:0] CACHEABLE     = 4'd3;
  parameter logic [CACHE_W-1:0] WT_FIRST      = 4'd8;
  parameter logic [CACHE_W-1:0] WB_LAST       = 4'd15;

  // ==========================================================
  // Types
  // ==========================================================
  typedef enum logic [1:0] {
    OMD_USER    = 2'd0,
    OMD_SUPER   = 2'd1,
    OMD_HYPER   = 2'd2,
    OMD_MACHINE = 2'd3
  } omd_t;

  typedef logic [2:0] rwx_t;  // Read, write and execute bits

  typedef struct packed {
    logic [PPN_W-1:0]   ppn;
    logic [RGN_W-1:0]   rgn;
    rwx_t               urwx;   // A zero field takes the region's value
    rwx_t               srwx;
    rwx_t               hrwx;
    rwx_t               mrwx;
    logic [CACHE_W-1:0] cache;
  } pte_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [ASID_W-1:0] asid;
    pte_t              pte;
  } tlb_entry_t;

  typedef struct packed {
    logic                   wr;
    logic                   way;
    logic [TLB_INDEX_W-1:0] index;
    tlb_entry_t             entry;  // Writing valid 0 invalidates the slot
  } tlb_write_t;

  typedef struct packed {
    logic [VADDR_W-1:0] vaddr;
    logic [ASID_W-1:0]  asid;
    omd_t               omd;
  } lookup_req_t;

  typedef struct packed {
    logic             load;
    logic             store;
    logic [ROB_W-1:0] rob;
  } data_tag_t;

  typedef struct packed {
    logic                        valid;
    tlb_entry_t                  entry;
    logic [PPN_W+PAGE_SHIFT-1:0] paddr;
    logic [VADDR_W-1:0]          vaddr;
  } tlb_result_t;

  typedef struct packed {
    logic [VADDR_W-PAGE_SHIFT-1:0] vpn;   // vaddr[31:16]
    logic [ASID_W-1:0]             asid;
  } miss_t;

  typedef struct packed {
    rwx_t               rwx;
    logic [CACHE_W-1:0] cache;
  } mode_attr_t;

  typedef struct packed {
    mode_attr_t [3:0] at;  // Indexed by omd_t
  } region_attr_t;

  typedef struct packed {
    logic             wr;
    logic [RGN_W-1:0] rgn;
    region_attr_t     attr;
  } region_write_t;

  // Region code decides first, and the entry may only narrow a cacheable region
  function automatic logic [CACHE_W-1:0] merge_cache(input logic [CACHE_W-1:0] rgn_c,
                                                     input logic [CACHE_W-1:0] ent_c);
    logic [CACHE_W-1:0] res;
    case (rgn_c) inside
      NC_NB, NON_CACHEABLE: res = rgn_c;
      CACHEABLE_NB:         res = (ent_c == CACHEABLE) ? CACHEABLE_NB : ent_c;
      CACHEABLE:            res = ent_c;
      [WT_FIRST:WB_LAST]:   res = (ent_c <= NON_CACHEABLE) ? ent_c : rgn_c;
      default:              res = NC_NB;  // Invalid region codes fall back to uncached
    endcase
    return res;
  endfunction

endpackage

//--- hw/tlb_region_table.sv
// Eight regions written through a plain config port, and a write is seen by reads from the next cycle
`timescale 1ns/1ps

module tlb_region_table (
  input  logic                         clk,
  input  logic                         rst,
  input  tlb_pkg::region_write_t       wr_i,
  input  logic [tlb_pkg::RGN_W-1:0]    rgn_a_i,   // Data channel region
  input  logic [tlb_pkg::RGN_W-1:0]    rgn_b_i,   // Fetch channel region
  output tlb_pkg::region_attr_t        attr_a_o,
  output tlb_pkg::region_attr_t        attr_b_o
);

  localparam int REGIONS = 2 ** tlb_pkg::RGN_W;

  tlb_pkg::region_attr_t tbl_q [REGIONS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < REGIONS; r++) begin
        tbl_q[r] <= '0;  // No permissions and uncached until configured
      end
    end else if (wr_i.wr) begin
      tbl_q[wr_i.rgn] <= wr_i.attr;
    end
  end

  // Combinational reads feed the merge on the registered entries
  assign attr_a_o = tbl_q[rgn_a_i];
  assign attr_b_o = tbl_q[rgn_b_i];

endmodule

//--- hw/tlb_top.sv
// Data and fetch channels each own a bank copy, and both copies share one write port
`timescale 1ns/1ps

module tlb_top #(
  parameter int MISSQ_DEPTH    = 16,
  parameter int WALKER_CREDITS = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  tlb_pkg::tlb_write_t    tlb_wr_i,       // Entry writes from the walker or OS
  input  tlb_pkg::region_write_t rgn_wr_i,       // Region table config
  input  logic                   d_req_valid_i,
  input  tlb_pkg::lookup_req_t   d_req_i,
  input  tlb_pkg::data_tag_t     d_tag_i,
  input  logic                   d_stall_i,
  input  logic                   f_req_valid_i,
  input  tlb_pkg::lookup_req_t   f_req_i,
  input  logic                   credit_i,
  output tlb_pkg::tlb_result_t   d_result_o,
  output tlb_pkg::data_tag_t     d_tag_o,
  output tlb_pkg::tlb_result_t   f_result_o,
  output logic                   miss_valid_o,
  output tlb_pkg::miss_t         miss_o
);

  logic                  d_hit;
  logic                  f_hit;
  tlb_pkg::tlb_entry_t   d_hit_entry;
  tlb_pkg::tlb_entry_t   f_hit_entry;
  logic                  d_pending;
  logic                  f_pending;
  tlb_pkg::tlb_result_t  d_res;
  tlb_pkg::tlb_result_t  f_res;
  tlb_pkg::omd_t         d_omd;
  tlb_pkg::omd_t         f_omd;
  logic                  d_miss;
  logic                  f_miss;
  tlb_pkg::miss_t        d_miss_entry;
  tlb_pkg::miss_t        f_miss_entry;
  tlb_pkg::region_attr_t d_attr;
  tlb_pkg::region_attr_t f_attr;
  tlb_pkg::tlb_entry_t   d_merged;
  tlb_pkg::tlb_entry_t   f_merged;

  // ==========================================================
  // Data channel
  // ==========================================================
  tlb_way_bank i_d_bank (
    .clk, .rst, .wr_i(tlb_wr_i), .req_i(d_req_i), .hit_o(d_hit), .hit_entry_o(d_hit_entry)
  );

  tlb_lookup_stage #(.HAS_TAG(1'b1)) i_d_stage (
    .clk, .rst, .req_valid_i(d_req_valid_i), .stall_i(d_stall_i), .req_i(d_req_i),
    .tag_i(d_tag_i), .hit_i(d_hit), .hit_entry_i(d_hit_entry), .pending_i(d_pending),
    .result_o(d_res), .omd_o(d_omd), .tag_o(d_tag_o), .miss_o(d_miss),
    .miss_o_entry(d_miss_entry)
  );

  tlb_attr_merge i_d_merge (
    .entry_i(d_res.entry), .omd_i(d_omd), .attr_i(d_attr), .entry_o(d_merged)
  );

  // ==========================================================
  // Fetch channel
  // ==========================================================
  tlb_way_bank i_f_bank (
    .clk, .rst, .wr_i(tlb_wr_i), .req_i(f_req_i), .hit_o(f_hit), .hit_entry_o(f_hit_entry)
  );

  tlb_lookup_stage #(.HAS_TAG(1'b0)) i_f_stage (
    .clk, .rst, .req_valid_i(f_req_valid_i), .stall_i(1'b0), .req_i(f_req_i),
    .tag_i('0), .hit_i(f_hit), .hit_entry_i(f_hit_entry), .pending_i(f_pending),
    .result_o(f_res), .omd_o(f_omd), .tag_o(), .miss_o(f_miss),
    .miss_o_entry(f_miss_entry)
  );

  tlb_attr_merge i_f_merge (
    .entry_i(f_res.entry), .omd_i(f_omd), .attr_i(f_attr), .entry_o(f_merged)
  );

  // Results leave with the merged entry in place of the raw one
  always_comb begin
    d_result_o       = d_res;
    d_result_o.entry = d_merged;
    f_result_o       = f_res;
    f_result_o.entry = f_merged;
  end

  // ==========================================================
  // Shared blocks
  // ==========================================================
  tlb_region_table i_regions (
    .clk, .rst, .wr_i(rgn_wr_i), .rgn_a_i(d_res.entry.pte.rgn), .rgn_b_i(f_res.entry.pte.rgn),
    .attr_a_o(d_attr), .attr_b_o(f_attr)
  );

  // Fetch sits on port a so it enqueues ahead of data
  tlb_miss_queue #(
    .MISSQ_DEPTH(MISSQ_DEPTH),
    .WALKER_CREDITS(WALKER_CREDITS)
  ) i_missq (
    .clk, .rst,
    .push_a_i(f_miss), .miss_a_i(f_miss_entry),
    .push_b_i(d_miss), .miss_b_i(d_miss_entry),
    .probe_a_i(f_miss_entry), .probe_b_i(d_miss_entry),
    .pending_a_o(f_pending), .pending_b_o(d_pending),
    .credit_i, .miss_valid_o, .miss_o
  );

endmodule

//--- hw/tlb_way_bank.sv
// Asynchronous read, so a write shows up in lookups from the next cycle, and way 0 wins a double hit
`timescale 1ns/1ps

module tlb_way_bank (
  input  logic                 clk,
  input  logic                 rst,
  input  tlb_pkg::tlb_write_t  wr_i,         // Shared write port, same for every bank copy
  input  tlb_pkg::lookup_req_t req_i,
  output logic                 hit_o,
  output tlb_pkg::tlb_entry_t  hit_entry_o
);

  localparam int SETS = 2 ** tlb_pkg::TLB_INDEX_W;

  tlb_pkg::tlb_entry_t mem_q [2][SETS];  // Entry payload per way
  logic [SETS-1:0]     vld_q [2];        // Valid bits kept apart so reset can clear them

  logic [tlb_pkg::TLB_INDEX_W-1:0] idx;
  logic [tlb_pkg::TAG_W-1:0]       tag;
  tlb_pkg::tlb_entry_t             rd [2];
  logic [1:0]                      way_hit;

  assign idx = req_i.vaddr[tlb_pkg::PAGE_SHIFT +: tlb_pkg::TLB_INDEX_W];
  assign tag = req_i.vaddr[tlb_pkg::VADDR_W-1 -: tlb_pkg::TAG_W];

  // ==========================================================
  // Write port
  // ==========================================================
  always_ff @(posedge clk) begin
    if (wr_i.wr) begin
      mem_q[wr_i.way][wr_i.index] <= wr_i.entry;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q[0] <= '0;  // Empty memory never hits
      vld_q[1] <= '0;
    end else if (wr_i.wr) begin
      vld_q[wr_i.way][wr_i.index] <= wr_i.entry.valid;
    end
  end

  // ==========================================================
  // Compare
  // ==========================================================
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      rd[w]       = mem_q[w][idx];
      rd[w].valid = vld_q[w][idx];  // Stored valid field is not trusted after reset
      way_hit[w]  = rd[w].valid && (rd[w].tag == tag) && (rd[w].asid == req_i.asid);
    end
  end

  assign hit_o       = |way_hit;
  assign hit_entry_o = way_hit[0] ? rd[0] : rd[1];

  // An unknown target would corrupt a set that later lookups in the other bank copy disagree on
  a_wr_target_known: assert property (@(posedge clk) disable iff (rst)
    wr_i.wr |-> !$isunknown({wr_i.way, wr_i.index}));

endmodule
